/* verilog/xlate_pkg.sv */
//////////////////////////////////////////////////
// remote address translation package
// widths, EVA field layouts, request and NPA
// bundles, region encoding for the EVA to NPA stage
//////////////////////////////////////////////////

`default_nettype none

package xlate_pkg;

  // field widths, tied to the EVA layouts below
  localparam int eva_w_c        = 32;
  localparam int epa_w_c        = 16;
  localparam int pod_x_w_c      = 3;
  localparam int x_subcord_w_c  = 4;
  localparam int pod_y_w_c      = 3;
  localparam int y_subcord_w_c  = 3;

  // region tags
  localparam int         dram_bit_c       = 31;
  localparam logic [1:0] global_tag_c     = 2'b01;
  localparam logic [2:0] tile_group_tag_c = 3'b001;

  typedef logic [eva_w_c-1:0]       eva_t;
  typedef logic [epa_w_c-1:0]       epa_t;
  typedef logic [pod_x_w_c-1:0]     pod_x_t;
  typedef logic [x_subcord_w_c-1:0] x_subcord_t;
  typedef logic [pod_y_w_c-1:0]     pod_y_t;
  typedef logic [y_subcord_w_c-1:0] y_subcord_t;
  // global coords are pod then subcoord
  typedef logic [pod_x_w_c+x_subcord_w_c-1:0] x_cord_t;
  typedef logic [pod_y_w_c+y_subcord_w_c-1:0] y_cord_t;

  // EVA viewed as a global address
  typedef struct packed {
    logic [1:0]  remote;
    logic [5:0]  y_cord;
    logic [6:0]  x_cord;
    logic [14:0] addr;
    logic [1:0]  low_bits;
  } global_addr_s;

  // EVA viewed as a tile-group address
  typedef struct packed {
    logic [2:0]  remote;
    logic [5:0]  x_cord;
    logic [4:0]  y_cord;
    logic [15:0] addr;
    logic [1:0]  low_bits;
  } tile_group_addr_s;

  // one core request
  typedef struct packed {
    eva_t       eva;
    x_subcord_t tgo_x;
    y_subcord_t tgo_y;
    logic       dram_enable;
  } xlate_req_s;

  // translated destination
  typedef struct packed {
    x_cord_t x_cord;
    y_cord_t y_cord;
    epa_t    epa;
    logic    invalid;
  } npa_s;

  typedef enum logic [1:0] {
    region_dram,
    region_global,
    region_tile_group,
    region_none
  } region_e;

endpackage

`default_nettype wire

/* verilog/dram_stripe_hash.sv */
//////////////////////////////////////////////////
// DRAM striping hash
// spreads DRAM cache lines over the north and
// south vcache rows, one line per vcache column
//////////////////////////////////////////////////

`default_nettype none

module dram_stripe_hash #(
  parameter int vcache_block_words_p = 8,
  parameter int vcache_size_words_p  = 1024
) (
  input  var xlate_pkg::eva_t   eva_i,
  input  var xlate_pkg::pod_x_t pod_x_i,
  input  var xlate_pkg::pod_y_t pod_y_i,
  output xlate_pkg::npa_s       npa_o
);

  // word offset inside a line
  localparam int offset_w_lp = $clog2(vcache_block_words_p);
  // lines one vcache can hold
  localparam int set_w_lp    = $clog2(vcache_size_words_p / vcache_block_words_p);
  localparam int col_w_lp    = xlate_pkg::x_subcord_w_c;
  // half select sits right above the column bits
  localparam int half_bit_lp = offset_w_lp + col_w_lp;

  // DRAM word address, bit 31 is only the region flag
  logic [28:0]              word_addr;
  logic [offset_w_lp-1:0]   word_offset;
  xlate_pkg::x_subcord_t    column;
  logic                     south;
  logic [set_w_lp-1:0]      set_index;
  xlate_pkg::pod_y_t        pod_north;
  xlate_pkg::pod_y_t        pod_south;

  assign word_addr   = eva_i[30:2];
  assign word_offset = word_addr[offset_w_lp-1:0];
  // consecutive lines walk across the columns first
  assign column      = word_addr[offset_w_lp +: col_w_lp];
  // then alternate north and south
  assign south       = word_addr[half_bit_lp];
  // what is left of the line index, within one vcache
  assign set_index   = word_addr[half_bit_lp+1 +: set_w_lp];

  // north vcaches are the bottom row of the pod above, pod y wraps
  assign pod_north = pod_y_i - xlate_pkg::pod_y_t'(1);
  // south vcaches are the top row of the pod below
  assign pod_south = pod_y_i + xlate_pkg::pod_y_t'(1);

  always_comb begin
    npa_o.x_cord = {pod_x_i, column};
    if (south) begin
      npa_o.y_cord = {pod_south, {xlate_pkg::y_subcord_w_c{1'b0}}};
    end else begin
      npa_o.y_cord = {pod_north, {xlate_pkg::y_subcord_w_c{1'b1}}};
    end
    npa_o.epa     = xlate_pkg::epa_t'({set_index, word_offset});
    // every DRAM address hashes somewhere
    npa_o.invalid = 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/direct_region_decode.sv */
//////////////////////////////////////////////////
// direct region decoder
// classifies the EVA and maps global, tile-group
// and block-RAM addresses straight to an NPA
//////////////////////////////////////////////////

`default_nettype none

module direct_region_decode #(
  parameter int vcache_size_words_p = 1024
) (
  input  var xlate_pkg::eva_t       eva_i,
  input  var xlate_pkg::x_subcord_t tgo_x_i,
  input  var xlate_pkg::y_subcord_t tgo_y_i,
  input  var xlate_pkg::pod_x_t     pod_x_i,
  input  var xlate_pkg::pod_y_t     pod_y_i,
  output xlate_pkg::npa_s           npa_o,
  output xlate_pkg::region_e        region_o
);

  // word address bits of one vcache
  localparam int lg_size_lp   = $clog2(vcache_size_words_p);
  localparam int bram_x_lsb   = 2 + lg_size_lp;
  localparam int bram_row_bit = bram_x_lsb + xlate_pkg::x_subcord_w_c;

  xlate_pkg::global_addr_s     global_addr;
  xlate_pkg::tile_group_addr_s tg_addr;
  logic                        is_dram;
  logic                        is_global;
  logic                        is_tile_group;

  // block-RAM mapping pieces
  xlate_pkg::x_subcord_t       bram_x_sub;
  logic                        bram_south;
  xlate_pkg::pod_y_t           bram_pod_y;

  // same bits, two views
  assign global_addr = eva_i;
  assign tg_addr     = eva_i;

  assign is_dram       = eva_i[xlate_pkg::dram_bit_c];
  assign is_global     = global_addr.remote == xlate_pkg::global_tag_c;
  assign is_tile_group = tg_addr.remote == xlate_pkg::tile_group_tag_c;

  // column from the bits above one vcache capacity
  assign bram_x_sub = eva_i[bram_x_lsb +: xlate_pkg::x_subcord_w_c];
  // 1 goes to the pod below, 0 to the pod above
  assign bram_south = eva_i[bram_row_bit];
  assign bram_pod_y = bram_south ? pod_y_i + xlate_pkg::pod_y_t'(1)
                                 : pod_y_i - xlate_pkg::pod_y_t'(1);

  always_comb begin
    npa_o.invalid = 1'b0;
    // priority follows the tag width, dram bit first
    if (is_dram) begin
      region_o     = xlate_pkg::region_dram;
      npa_o.x_cord = {pod_x_i, bram_x_sub};
      npa_o.y_cord = {bram_pod_y, {xlate_pkg::y_subcord_w_c{~bram_south}}};
      // word address inside the vcache
      npa_o.epa    = xlate_pkg::epa_t'(eva_i[2 +: lg_size_lp]);
    end else if (is_global) begin
      region_o     = xlate_pkg::region_global;
      // coordinates sit in the EVA as they are
      npa_o.x_cord = global_addr.x_cord;
      npa_o.y_cord = global_addr.y_cord;
      npa_o.epa    = xlate_pkg::epa_t'(global_addr.addr);
    end else if (is_tile_group) begin
      region_o     = xlate_pkg::region_tile_group;
      // offset from origin, wraps inside the pod
      npa_o.x_cord = {pod_x_i, xlate_pkg::x_subcord_t'(tg_addr.x_cord + tgo_x_i)};
      npa_o.y_cord = {pod_y_i, xlate_pkg::y_subcord_t'(tg_addr.y_cord + tgo_y_i)};
      npa_o.epa    = tg_addr.addr;
    end else begin
      region_o      = xlate_pkg::region_none;
      npa_o.x_cord  = '0;
      npa_o.y_cord  = '0;
      npa_o.epa     = '0;
      npa_o.invalid = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/npa_select.sv */
//////////////////////////////////////////////////
// NPA select
// picks the hash or decoder result by region,
// flags EVAs that match no region
//////////////////////////////////////////////////

`default_nettype none

module npa_select (
  input  var xlate_pkg::region_e region_i,
  input  var logic               dram_enable_i,
  input  var xlate_pkg::npa_s    hash_npa_i,
  input  var xlate_pkg::npa_s    dec_npa_i,
  output xlate_pkg::npa_s        npa_o
);

  always_comb begin
    unique case (region_i)
      xlate_pkg::region_dram: begin
        // striping only in DRAM mode
        if (dram_enable_i) begin
          npa_o = hash_npa_i;
        end else begin
          // vcaches act as block RAM
          npa_o = dec_npa_i;
        end
      end
      xlate_pkg::region_global,
      xlate_pkg::region_tile_group: begin
        npa_o = dec_npa_i;
      end
      default: begin
        // no region matched
        npa_o.x_cord  = '0;
        npa_o.y_cord  = '0;
        npa_o.epa     = '0;
        npa_o.invalid = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/npa_credit_stage.sv */
//////////////////////////////////////////////////
// NPA output stage
// registers accepted requests for one cycle and
// tracks link credits towards the network
//////////////////////////////////////////////////

`default_nettype none

module npa_credit_stage #(
  parameter int credits_p = 4
) (
  input  var logic            clk_i,
  input  var logic            rst_i,
  input  var logic            v_i,
  input  var xlate_pkg::npa_s npa_i,
  input  var logic            credit_i,
  output logic                ready_o,
  output logic                v_o,
  output xlate_pkg::npa_s     npa_o
);

  // room for 0 .. credits_p
  localparam int cnt_w_lp = $clog2(credits_p + 1);

  logic [cnt_w_lp-1:0] credit_cnt_r;
  logic                accept;
  logic                v_r;
  xlate_pkg::npa_s     npa_r;

  // any credit left means a slot on the link
  assign ready_o = credit_cnt_r != '0;
  assign accept  = v_i & ready_o;

  // credit is taken at acceptance, so the
  // registered beat always owns one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_cnt_r <= cnt_w_lp'(credits_p);
    end else begin
      unique case ({credit_i, accept})
        2'b10: begin
          credit_cnt_r <= credit_cnt_r + 1'b1;
        end
        2'b01: begin
          credit_cnt_r <= credit_cnt_r - 1'b1;
        end
        default: begin
          // none, or returned and spent together
          credit_cnt_r <= credit_cnt_r;
        end
      endcase
    end
  end

  // valid lasts one cycle per accepted request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= accept;
    end
  end

  // payload only loads on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      npa_r <= npa_i;
    end
  end

  assign v_o   = v_r;
  assign npa_o = npa_r;

endmodule

`default_nettype wire

/* verilog/remote_xlate_top.sv */
//////////////////////////////////////////////////
// remote address translation top
// EVA to NPA for a manycore tile, hash and decoder
// side by side, then a credited output register
//////////////////////////////////////////////////

`default_nettype none

module remote_xlate_top #(
  parameter int vcache_block_words_p = 8,
  parameter int vcache_size_words_p  = 1024,
  parameter int credits_p            = 4
) (
  input  var logic                  clk_i,
  input  var logic                  rst_i,
  // core request
  input  var logic                  req_v_i,
  input  var xlate_pkg::xlate_req_s req_i,
  output logic                      req_ready_o,
  // position of this pod
  input  var xlate_pkg::pod_x_t     pod_x_i,
  input  var xlate_pkg::pod_y_t     pod_y_i,
  // towards the network
  output logic                      out_v_o,
  output xlate_pkg::npa_s           out_o,
  input  var logic                  credit_i
);

  xlate_pkg::npa_s    hash_npa;
  xlate_pkg::npa_s    dec_npa;
  xlate_pkg::npa_s    sel_npa;
  xlate_pkg::region_e region;

  // DRAM striping
  dram_stripe_hash #(
    .vcache_block_words_p(vcache_block_words_p),
    .vcache_size_words_p (vcache_size_words_p)
  ) hash_i (
    .eva_i  (req_i.eva),
    .pod_x_i(pod_x_i),
    .pod_y_i(pod_y_i),
    .npa_o  (hash_npa)
  );

  // global, tile-group, block RAM
  direct_region_decode #(
    .vcache_size_words_p(vcache_size_words_p)
  ) decode_i (
    .eva_i   (req_i.eva),
    .tgo_x_i (req_i.tgo_x),
    .tgo_y_i (req_i.tgo_y),
    .pod_x_i (pod_x_i),
    .pod_y_i (pod_y_i),
    .npa_o   (dec_npa),
    .region_o(region)
  );

  npa_select select_i (
    .region_i     (region),
    .dram_enable_i(req_i.dram_enable),
    .hash_npa_i   (hash_npa),
    .dec_npa_i    (dec_npa),
    .npa_o        (sel_npa)
  );

  // one register stage with link credits
  npa_credit_stage #(
    .credits_p(credits_p)
  ) stage_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (req_v_i),
    .npa_i   (sel_npa),
    .credit_i(credit_i),
    .ready_o (req_ready_o),
    .v_o     (out_v_o),
    .npa_o   (out_o)
  );

endmodule

`default_nettype wire

/* tb/tb_xlate_model.svh */
//////////////////////////////////////////////////
// reference EVA to NPA translation and the LFSR
// step used by the translation testbench
//////////////////////////////////////////////////

`ifndef tb_xlate_model_svh
`define tb_xlate_model_svh

// Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ 32'h8020_0003;
  end
  return state >> 1;
endfunction

// which translation path a request takes
function automatic int request_kind(input xlate_pkg::xlate_req_s req);
  if (req.eva[31]) begin
    return req.dram_enable ? kind_hash_c : kind_bram_c;
  end
  if (req.eva[31:30] == 2'b01) begin
    return kind_global_c;
  end
  if (req.eva[31:29] == 3'b001) begin
    return kind_tile_c;
  end
  return kind_none_c;
endfunction

function automatic xlate_pkg::npa_s translate_ref(
  input xlate_pkg::xlate_req_s req,
  input xlate_pkg::pod_x_t     pod_x,
  input xlate_pkg::pod_y_t     pod_y
);
  int unsigned     word;
  int unsigned     line;
  int unsigned     half;
  xlate_pkg::npa_s npa;
  npa  = '0;
  // word address below the DRAM flag
  word = int'(req.eva[30:2]);
  line = word / block_words_c;
  case (request_kind(req))
    kind_hash_c, kind_bram_c: begin
      if (req.dram_enable) begin
        // lines go round 16 columns, then flip north and south
        npa.x_cord = {pod_x, 4'(line % 16)};
        half       = (line / 16) % 2;
        npa.epa    = 16'(((line / 32) % (size_words_c / block_words_c)) * block_words_c
                         + word % block_words_c);
      end else begin
        // one vcache capacity per column
        npa.x_cord = {pod_x, 4'((word / size_words_c) % 16)};
        half       = (word / size_words_c / 16) % 2;
        npa.epa    = 16'(word % size_words_c);
      end
      // 1 is the pod below at row 0, 0 the pod above at the last row
      if (half == 1) begin
        npa.y_cord = {xlate_pkg::pod_y_t'(pod_y + 3'd1), 3'b000};
      end else begin
        npa.y_cord = {xlate_pkg::pod_y_t'(pod_y - 3'd1), 3'b111};
      end
    end
    kind_global_c: begin
      npa.y_cord = req.eva[29:24];
      npa.x_cord = req.eva[23:17];
      npa.epa    = {1'b0, req.eva[16:2]};
    end
    kind_tile_c: begin
      // origin plus offset, wraps inside this pod
      npa.x_cord = {pod_x, 4'((int'(req.eva[28:23]) + int'(req.tgo_x)) % 16)};
      npa.y_cord = {pod_y, 3'((int'(req.eva[22:18]) + int'(req.tgo_y)) % 8)};
      npa.epa    = req.eva[17:2];
    end
    default: begin
      npa.invalid = 1'b1;
    end
  endcase
  return npa;
endfunction

`endif

/* tb/tb_remote_xlate.sv */
//////////////////////////////////////////////////
// testbench for the remote address translation
// stage, LFSR requests, credit return model and
// a reference translation checked by assertions
//////////////////////////////////////////////////

`default_nettype none

module tb_remote_xlate;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int     block_words_c = 8;
  localparam int     size_words_c  = 1024;
  localparam int     credits_c     = 4;
  localparam int     clk_period_c  = 40;
  localparam int     n_requests_c  = 3000;
  localparam longint watchdog_ns_c = longint'(n_requests_c) * clk_period_c * 4;

  // translation paths, for the hit tally
  localparam int kind_hash_c   = 0;
  localparam int kind_bram_c   = 1;
  localparam int kind_global_c = 2;
  localparam int kind_tile_c   = 3;
  localparam int kind_none_c   = 4;

  logic                  clk_i;
  logic                  rst_i;
  logic                  req_v_i;
  xlate_pkg::xlate_req_s req_i;
  logic                  req_ready_o;
  xlate_pkg::pod_x_t     pod_x_i;
  xlate_pkg::pod_y_t     pod_y_i;
  logic                  out_v_o;
  xlate_pkg::npa_s       out_o;
  logic                  credit_i;

  logic [31:0]     lfsr_state = 32'd22;
  // expected beat for the next cycle
  logic            exp_v_r;
  xlate_pkg::npa_s exp_npa_r;
  int              exp_kind_r;
  // credits the DUT holds, by our own count
  int              held_credits = credits_c;
  // beats the network got and has not paid back
  int              net_pending;
  int              hold_left;
  int              kind_hits[5] = '{default: 0};
  int              value_errors;
  int              handshake_errors;
  int              coverage_gaps;

  `include "tb_xlate_model.svh"

  remote_xlate_top dut_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_v_i    (req_v_i),
    .req_i      (req_i),
    .req_ready_o(req_ready_o),
    .pod_x_i    (pod_x_i),
    .pod_y_i    (pod_y_i),
    .out_v_o    (out_v_o),
    .out_o      (out_o),
    .credit_i   (credit_i)
  );

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  task automatic value_error(input string msg);
    value_errors++;
    $display("Error %0t: %s", $time, msg);
  endtask

  task automatic handshake_error(input string msg);
    handshake_errors++;
    $display("Handshake failure at %0t: %s", $time, msg);
  endtask

  // new request with a random region tag
  task automatic drive_request();
    xlate_pkg::xlate_req_s next_req;
    logic [1:0]            region_sel;
    next_req.eva = rand_bits(32);
    region_sel   = 2'(rand_bits(2));
    case (region_sel)
      2'd0: next_req.eva[31] = 1'b1;
      2'd1: next_req.eva[31:30] = 2'b01;
      2'd2: next_req.eva[31:29] = 3'b001;
      default: next_req.eva[31:29] = 3'b000;
    endcase
    next_req.tgo_x       = xlate_pkg::x_subcord_t'(rand_bits(4));
    next_req.tgo_y       = xlate_pkg::y_subcord_t'(rand_bits(3));
    next_req.dram_enable = rand_bits(1) != 0;
    // valid about three cycles in four
    req_v_i <= rand_bits(2) != 0;
    req_i   <= next_req;
  endtask

  // pod y at both ends first, so the row wrap gets used
  task automatic move_pod(input int phase);
    pod_x_i <= xlate_pkg::pod_x_t'(rand_bits(3));
    case (phase)
      0: pod_y_i <= '0;
      1: pod_y_i <= '1;
      default: pod_y_i <= xlate_pkg::pod_y_t'(rand_bits(3));
    endcase
  endtask

  // network side, pays credits back after random holds
  task automatic network_step();
    if (out_v_o) begin
      net_pending++;
    end
    if (credit_i) begin
      net_pending--;
    end
    if (hold_left > 0) begin
      hold_left--;
      credit_i <= 1'b0;
    end else if (net_pending > 0) begin
      if (rand_bits(3) == 0) begin
        hold_left = int'(rand_bits(3));
        credit_i <= 1'b0;
      end else begin
        credit_i <= 1'b1;
      end
    end else begin
      credit_i <= 1'b0;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : check_output
    logic accept;
    accept = req_v_i & req_ready_o;
    if (rst_i) begin
      exp_v_r      <= 1'b0;
      held_credits <= credits_c;
    end else begin
      assert (out_v_o == exp_v_r) else
        value_error($sformatf("out_v_o is %0b, expected %0b", out_v_o, exp_v_r));
      if (out_v_o && exp_v_r) begin
        assert (out_o == exp_npa_r) else
          value_error($sformatf("kind %0d npa %h, expected %h",
                                exp_kind_r, out_o, exp_npa_r));
        // block RAM words stay inside one vcache
        if (exp_kind_r == kind_bram_c) begin
          assert (int'(out_o.epa) < size_words_c) else
            value_error($sformatf("block RAM epa %h past the vcache", out_o.epa));
        end
        kind_hits[exp_kind_r]++;
      end
      assert (held_credits <= credits_c) else
        handshake_error("more credits held than the link has");
      exp_v_r <= accept;
      if (accept) begin
        exp_npa_r  <= translate_ref(req_i, pod_x_i, pod_y_i);
        exp_kind_r <= request_kind(req_i);
      end
      held_credits <= held_credits + int'(credit_i) - int'(accept);
    end
  end

  // a beat on the link always owns a credit
  assert property (@(posedge clk_i) disable iff (rst_i)
                   out_v_o |-> (credits_c - held_credits) > 0)
    else handshake_error("out_v_o high with no credit outstanding");

  assert property (@(posedge clk_i) disable iff (rst_i)
                   req_ready_o == (held_credits != 0))
    else handshake_error("req_ready_o does not follow the credit count");

  initial begin : watchdog
    #(watchdog_ns_c);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns_c);
    $display("Verification failed");
    $finish;
  end

  initial begin : drive_requests
    int accepted;
    int phase;
    int k;
    rst_i    = 1'b1;
    req_v_i  = 1'b0;
    req_i    = '0;
    pod_x_i  = '0;
    pod_y_i  = '0;
    credit_i = 1'b0;
    accepted = 0;
    phase    = -1;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    // link idle with all credits
    assert (!out_v_o && req_ready_o) else
      handshake_error("outputs not idle and ready after reset");
    while (accepted < n_requests_c) begin
      @(posedge clk_i);
      if (req_v_i && req_ready_o) begin
        accepted++;
      end
      network_step();
      if (accepted / 1000 != phase && accepted < n_requests_c) begin
        phase = accepted / 1000;
        move_pod(phase);
      end
      // a refused request stays on the inputs
      if (accepted >= n_requests_c) begin
        req_v_i <= 1'b0;
      end else if (!req_v_i || req_ready_o) begin
        drive_request();
      end
    end
    // let the network pay every credit back
    do begin
      @(posedge clk_i);
      network_step();
    end while (held_credits != credits_c);
    @(posedge clk_i);
    for (k = 0; k < 5; k++) begin
      if (kind_hits[k] == 0) begin
        coverage_gaps++;
        $display("No checked translation of kind %0d", k);
      end
    end
    $display("value errors %0d, handshake errors %0d, coverage gaps %0d",
             value_errors, handshake_errors, coverage_gaps);
    if (value_errors + handshake_errors + coverage_gaps == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
verilog/xlate_pkg.sv
verilog/dram_stripe_hash.sv
verilog/direct_region_decode.sv
verilog/npa_select.sv
verilog/npa_credit_stage.sv
verilog/remote_xlate_top.sv
tb/tb_remote_xlate.sv

/* run_sim.sh */
#!/bin/sh
# build and run the remote address translation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_remote_xlate -f src.f --Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_remote_xlate)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^Verification passed$'; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
